// File: bench/frontend_testdata.txt
# Columns: test name, redirect address in hex or none, instructions to observe,
# commit mode (on or held), percent of cycles with decode ready
# A held test runs until the stream stops and its count is the expected total
queue_limit         none   12   held  100
queue_resume        none   40   on    100
backpressure        none   120  on    30
redirect_in_stall   2000   24   on    30
redirect_fast       3000   32   on    100
cross_line          1038   16   on    100
cross_line_stall    2f38   40   on    50
offset_drift        5024   48   on    80
redirect_limit      4000   8    held  100
limit_resume        none   24   on    60
line_end            1ff8   20   on    100
word_before_line    103c   12   on    100
slow_decode         none   40   on    10
back_to_back_a      6000   4    on    100
back_to_back_b      7000   12   on    100
stall_then_jump     none   30   on    20
jump_from_stall     8038   28   on    40
long_run            none   200  on    75

// File: all.f
+incdir+include
logic/fetch_pkg.sv
logic/block_predictor.sv
logic/ftq.sv
logic/instr_fetcher.sv
logic/frontend_top.sv
bench/frontend_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/fetch_pkg.sv
      - logic/block_predictor.sv
      - logic/ftq.sv
      - logic/instr_fetcher.sv
      - logic/frontend_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/frontend_tb.sv

// File: bench/frontend_tb.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module frontend_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD       = 20;
    localparam int DRIVE_DELAY      = 2;
    localparam int RESET_CYCLES     = 5;
    localparam int QUIET_CYCLES     = 40;
    localparam int CYCLES_PER_INSTR = 50;
    localparam int SEED             = 27360;
    localparam int BLOCK_BYTES      = 4 * `FETCH_WIDTH;
    localparam     TESTDATA         = "bench/frontend_testdata.txt";

    logic               clk;
    logic               rst;
    logic               redirect_i;
    logic [`ADDR_W-1:0] redirect_pc_i;
    logic               commit_i;
    logic               decode_ready_i;
    fetch_instr_t       instr_o;
    logic               instr_valid_o;

    // Test table loaded from the data file
    string              test_name   [$];
    bit                 test_redir  [$];
    logic [`ADDR_W-1:0] test_pc     [$];
    int                 test_count  [$];
    bit                 test_commit [$];
    int                 test_ready  [$];

    // Reference model of the instruction stream
    logic [`ADDR_W-1:0] expected_pc;
    logic [`ADDR_W-1:0] block_start;
    int                 in_block;
    int                 pending_commits;
    int                 error_count;
    int                 watchdog_cycles;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    frontend_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .commit_i       (commit_i),
        .decode_ready_i (decode_ready_i),
        .instr_o        (instr_o),
        .instr_valid_o  (instr_valid_o)
    );

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_values(input string name, input string what,
                                  input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("error test %s, %s: expected %0h, actual %0h",
                     name, what, expected, actual);
            abort_run();
        end
    endtask

    // Words of a line-crossing block at or past the next line boundary
    function automatic logic split_expected(input logic [`ADDR_W-1:0] start,
                                            input logic [`ADDR_W-1:0] pc);
        logic [`ADDR_W-1:0] offset;
        logic [`ADDR_W-1:0] boundary;
        offset   = start % `LINE_BYTES;
        boundary = start - offset + `LINE_BYTES;
        return (offset + BLOCK_BYTES > `LINE_BYTES) && (pc >= boundary);
    endfunction

    task automatic load_tests();
        int                 fd;
        int                 fields;
        int                 count;
        int                 ready;
        int                 budget;
        string              line;
        string              name;
        string              redir;
        string              mode;
        logic [`ADDR_W-1:0] pc;
        fd = $fopen(TESTDATA, "r");
        if (fd == 0) begin
            $display("could not open test data file %s", TESTDATA);
            abort_run();
        end else begin
            budget = 2 * RESET_CYCLES;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %s %d %s %d", name, redir, count, mode, ready);
                if (fields != 5 || !(mode == "on" || mode == "held")) begin
                    $display("malformed test data line: %s", line);
                    abort_run();
                end else begin
                    pc = '0;
                    if (redir != "none") begin
                        void'($sscanf(redir, "%h", pc));
                    end
                    test_name.push_back(name);
                    test_redir.push_back(redir != "none");
                    test_pc.push_back(pc);
                    test_count.push_back(count);
                    test_commit.push_back(mode == "on");
                    test_ready.push_back(ready);
                    budget += CYCLES_PER_INSTR * count;
                    if (mode == "held") begin
                        budget += QUIET_CYCLES;
                    end
                end
            end
            $fclose(fd);
            // Watchdog starts once the whole budget is known
            watchdog_cycles = budget;
        end
    endtask

    // One clock cycle of backend and decode stimulus
    task automatic drive_cycle(input bit redir, input logic [`ADDR_W-1:0] pc,
                               input bit commit_on, input int ready_pct);
        @(posedge clk);
        #(DRIVE_DELAY);
        decode_ready_i = ($urandom_range(99, 0) < ready_pct);
        redirect_i     = redir;
        redirect_pc_i  = pc;
        if (redir) begin
            commit_i        = commit_on;
            // Redirecting block keeps its FTQ slot until committed
            pending_commits = 1;
            in_block        = 0;
            expected_pc     = pc;
            block_start     = pc;
        end else if (commit_on && pending_commits > 0) begin
            commit_i = 1'b1;
            pending_commits--;
        end else begin
            commit_i = 1'b0;
        end
        @(negedge clk);
    endtask

    task automatic take_transfer(input string name, output bit taken);
        taken = instr_valid_o && decode_ready_i;
        if (taken) begin
            compare_values(name, "pc", expected_pc, instr_o.pc);
            compare_values(name, "line_split", split_expected(block_start, expected_pc),
                           instr_o.line_split);
            expected_pc = expected_pc + 4;
            in_block++;
            if (in_block == `FETCH_WIDTH) begin
                in_block = 0;
                pending_commits++;
                block_start = block_start + BLOCK_BYTES;
            end
        end
    endtask

    task automatic run_test(input int idx);
        string name;
        int    seen;
        int    quiet;
        int    limit;
        bit    taken;
        name  = test_name[idx];
        seen  = 0;
        quiet = 0;
        if (test_redir[idx]) begin
            drive_cycle(1'b1, test_pc[idx], test_commit[idx], test_ready[idx]);
            drive_cycle(1'b0, '0, test_commit[idx], test_ready[idx]);
            compare_values(name, "valid after redirect", 0, instr_valid_o);
        end
        if (test_commit[idx]) begin
            while (seen < test_count[idx]) begin
                drive_cycle(1'b0, '0, 1'b1, test_ready[idx]);
                take_transfer(name, taken);
                seen += taken;
            end
        end else begin
            // Uncommitted blocks and the partly consumed one hold FTQ slots
            limit = (`QUEUE_SIZE - 1 - pending_commits) * `FETCH_WIDTH - in_block;
            while (quiet < QUIET_CYCLES) begin
                drive_cycle(1'b0, '0, 1'b0, test_ready[idx]);
                quiet = instr_valid_o ? 0 : quiet + 1;
                take_transfer(name, taken);
                seen += taken;
            end
            compare_values(name, "instructions before stall", limit, seen);
            compare_values(name, "count in test data", test_count[idx], seen);
        end
        $display("test %s done, %0d instructions", name, seen);
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("front end stopped producing instructions within %0d cycles",
                 watchdog_cycles);
        abort_run();
    end

    initial begin
        rst             = 1'b1;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        commit_i        = 1'b0;
        decode_ready_i  = 1'b0;
        error_count     = 0;
        watchdog_cycles = 0;
        void'($urandom(SEED));
        load_tests();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst             = 1'b0;
        expected_pc     = `RESET_PC;
        block_start     = `RESET_PC;
        in_block        = 0;
        pending_commits = 0;
        for (int i = 0; i < test_name.size(); i++) begin
            run_test(i);
        end
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: logic/frontend_top.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module frontend_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_i,
    input  logic [`ADDR_W-1:0]      redirect_pc_i,
    input  logic                    commit_i,
    input  logic                    decode_ready_i,
    output fetch_pkg::fetch_instr_t instr_o,
    output logic                    instr_valid_o
);
    import fetch_pkg::*;

    // Predictor to FTQ
    fetch_block_t bpu_block;
    logic         queue_full;

    // FTQ to fetcher
    ftq_ifu_t ftq_ifu;
    logic     fetch_accept;

    block_predictor u_block_predictor (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_full_i  (queue_full),
        .block_o       (bpu_block)
    );

    ftq #(
        .QUEUE_SIZE (`QUEUE_SIZE)
    ) u_ftq (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i),
        .commit_i     (commit_i),
        .bpu_block_i  (bpu_block),
        .queue_full_o (queue_full),
        .ifu_o        (ftq_ifu),
        .ifu_accept_i (fetch_accept)
    );

    instr_fetcher u_instr_fetcher (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (redirect_i),
        .ifu_i          (ftq_ifu),
        .ifu_accept_o   (fetch_accept),
        .instr_o        (instr_o),
        .instr_valid_o  (instr_valid_o),
        .decode_ready_i (decode_ready_i)
    );

endmodule

// File: logic/instr_fetcher.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module instr_fetcher (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  fetch_pkg::ftq_ifu_t     ifu_i,
    output logic                    ifu_accept_o,
    output fetch_pkg::fetch_instr_t instr_o,
    output logic                    instr_valid_o,
    input  logic                    decode_ready_i
);
    import fetch_pkg::*;

    localparam int BUF_SIZE = 2 * `FETCH_WIDTH;
    localparam int PTR_W    = $clog2(BUF_SIZE);
    localparam int CNT_W    = $clog2(BUF_SIZE + 1);
    localparam int OFFSET_W = $clog2(`LINE_BYTES);

    // Highest fill level that still takes a whole block
    localparam logic [CNT_W-1:0] ACCEPT_LIMIT = CNT_W'(BUF_SIZE - `FETCH_WIDTH);

    fetch_instr_t                    buffer [BUF_SIZE];
    fetch_instr_t [`FETCH_WIDTH-1:0] expand;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_cnt;
    logic             has_room;
    logic             pop;

    assign has_room     = (count <= ACCEPT_LIMIT);
    assign ifu_accept_o = ifu_i.valid && has_room && !flush_i;

    assign instr_valid_o = (count != '0);
    assign instr_o       = buffer[head];
    assign pop           = instr_valid_o && decode_ready_i;

    assign push_cnt = ifu_accept_o ? CNT_W'(ifu_i.length) : '0;

    // Expand the head block into word addresses
    // Words past the line boundary of a cross-line block are marked split
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            expand[i].pc         = ifu_i.start_pc + `ADDR_W'(4 * i);
            expand[i].line_split = ifu_i.is_cross_cacheline &&
                (expand[i].pc[`ADDR_W-1:OFFSET_W] != ifu_i.start_pc[`ADDR_W-1:OFFSET_W]);
        end
    end

    // Whole block lands in one cycle
    always_ff @(posedge clk) begin
        if (ifu_accept_o) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (i < int'(ifu_i.length)) begin
                    buffer[tail + PTR_W'(i)] <= expand[i];
                end
            end
        end
    end

    // Redirect empties the buffer just like reset
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(pop);
            tail  <= tail + PTR_W'(push_cnt);
            count <= count + push_cnt - CNT_W'(pop);
        end
    end

endmodule

// File: logic/ftq.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module ftq #(
    parameter int QUEUE_SIZE = `QUEUE_SIZE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    commit_i,
    input  fetch_pkg::fetch_block_t bpu_block_i,
    output logic                    queue_full_o,
    output fetch_pkg::ftq_ifu_t     ifu_o,
    // Accept comes back combinationally in the same cycle
    input  logic                    ifu_accept_i
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_SIZE);

    fetch_block_t [QUEUE_SIZE-1:0] entries;
    fetch_block_t [QUEUE_SIZE-1:0] entries_next;

    logic [PTR_W-1:0] bpu_ptr;
    logic [PTR_W-1:0] ifu_ptr;
    logic [PTR_W-1:0] comm_ptr;
    logic [PTR_W-1:0] bpu_ptr_inc;
    logic [PTR_W-1:0] restart_ptr;

    assign bpu_ptr_inc = bpu_ptr + PTR_W'(1);

    // Redirected stream starts behind the block being committed
    assign restart_ptr = comm_ptr + PTR_W'(1) + PTR_W'(commit_i);

    // One slot stays empty so full and empty differ
    assign queue_full_o = (bpu_ptr_inc == comm_ptr);

    always_comb begin
        entries_next = entries;
        if (commit_i) begin
            entries_next[comm_ptr] = '0;
        end
        if (bpu_block_i.valid) begin
            entries_next[bpu_ptr] = bpu_block_i;
        end
        // Redirect drops every pending block
        if (flush_i) begin
            entries_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entries <= '0;
        end else begin
            entries <= entries_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bpu_ptr  <= '0;
            ifu_ptr  <= '0;
            comm_ptr <= '0;
        end else begin
            if (commit_i) begin
                comm_ptr <= comm_ptr + PTR_W'(1);
            end
            if (flush_i) begin
                bpu_ptr <= restart_ptr;
                ifu_ptr <= restart_ptr;
            end else begin
                if (bpu_block_i.valid) begin
                    bpu_ptr <= bpu_ptr_inc;
                end
                if (ifu_accept_i) begin
                    ifu_ptr <= ifu_ptr + PTR_W'(1);
                end
            end
        end
    end

    // Head block for the fetcher
    assign ifu_o.valid              = entries[ifu_ptr].valid;
    assign ifu_o.start_pc           = entries[ifu_ptr].start_pc;
    assign ifu_o.length             = entries[ifu_ptr].length;
    assign ifu_o.is_cross_cacheline = entries[ifu_ptr].is_cross_cacheline;

endmodule

// File: logic/block_predictor.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module block_predictor (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic [`ADDR_W-1:0]      redirect_pc_i,
    input  logic                    queue_full_i,
    output fetch_pkg::fetch_block_t block_o
);
    import fetch_pkg::*;

    localparam int BLOCK_BYTES = 4 * `FETCH_WIDTH;
    localparam int OFFSET_W    = $clog2(`LINE_BYTES);

    // One extra bit so the end offset of a block can pass the line size
    localparam logic [OFFSET_W:0] BLOCK_SPAN = (OFFSET_W + 1)'(BLOCK_BYTES);
    localparam logic [OFFSET_W:0] LINE_SPAN  = (OFFSET_W + 1)'(`LINE_BYTES);

    pred_state_e        state;
    pred_state_e        state_next;
    logic [`ADDR_W-1:0] pc;
    logic [OFFSET_W:0]  end_offset;
    logic               emit;

    // No block while stalled by the FTQ or in a redirect cycle
    assign emit = (state == pred_run) && !queue_full_i && !flush_i;

    // Byte offset just past the block, relative to its own line
    assign end_offset = {1'b0, pc[OFFSET_W-1:0]} + BLOCK_SPAN;

    assign block_o.valid              = emit;
    assign block_o.start_pc           = pc;
    assign block_o.length             = blk_len_t'(`FETCH_WIDTH);
    assign block_o.is_cross_cacheline = end_offset > LINE_SPAN;

    always_comb begin
        state_next = state;
        case (state)
            pred_idle: state_next = pred_run;
            pred_run:  state_next = pred_run;
            default:   state_next = pred_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pred_idle;
        end else begin
            state <= state_next;
        end
    end

    // Next block address
    always_ff @(posedge clk) begin
        if (flush_i) begin
            pc <= redirect_pc_i;
        end else if (state == pred_idle) begin
            pc <= `RESET_PC;
        end else if (emit) begin
            pc <= pc + `ADDR_W'(BLOCK_BYTES);
        end
    end

endmodule

// File: logic/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // Instruction address
    typedef logic [`ADDR_W-1:0] addr_t;

    // Instruction count of a block, wide enough to hold FETCH_WIDTH itself
    typedef logic [$clog2(`FETCH_WIDTH + 1)-1:0] blk_len_t;

    // Block written by the predictor and held in the FTQ
    typedef struct packed {
        logic     valid;
        addr_t    start_pc;
        blk_len_t length;
        logic     is_cross_cacheline;
    } fetch_block_t;

    // Head block presented to the fetcher
    typedef struct packed {
        logic     valid;
        addr_t    start_pc;
        blk_len_t length;
        logic     is_cross_cacheline;
    } ftq_ifu_t;

    // One instruction buffer entry, also the decode output
    typedef struct packed {
        addr_t pc;
        logic  line_split;
    } fetch_instr_t;

    // Predictor FSM
    typedef enum logic {
        pred_idle,
        pred_run
    } pred_state_e;

endpackage

// File: include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instructions carried by one fetch block
`define FETCH_WIDTH 4

// FTQ depth, must be a power of two
`define QUEUE_SIZE 4

// Instruction address width
`define ADDR_W 32

// First fetch address after reset
`define RESET_PC 32'h0000_1000

// Instruction cache line size in bytes
`define LINE_BYTES 64

`endif
